/* aib_cfg_pkg.sv */
//--------------------------------------------------------------------------
// AIB adapter read slice configuration
// Data path geometry, lane word types and loopback mode encoding
//--------------------------------------------------------------------------

package aib_cfg_pkg;

  //------------------------------------------------------------------------
  // Data path geometry
  //------------------------------------------------------------------------
  localparam int NUM_LANES = 4;            // Lanes on the FIFO data bus
  localparam int LANE_W    = 16;           // Bits per lane

  localparam int SYNC_STAGES = 2;          // Flops in each CSR synchronizer

  // One lane data word
  typedef logic [LANE_W-1:0] lane_t;

  // Full FIFO data bus, lane 0 in the low bits
  typedef lane_t [NUM_LANES-1:0] bus_t;

  //------------------------------------------------------------------------
  // Loopback mode field
  //------------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    LPBK_NONE     = 2'b00,                 // Normal mission traffic
    LPBK_FARSIDE  = 2'b01,                 // RX data turned back onto TX IO
    LPBK_NEARSIDE = 2'b10                  // Handled at the IO buffer
  } lpbk_mode_t;

endpackage

/* aib_bert_pkg.sv */
//--------------------------------------------------------------------------
// AIB adapter BERT definitions
// PRBS7 polynomial, per-lane seeds, error counter type and the
// parallel PRBS step used by both generator and checker
//--------------------------------------------------------------------------

package aib_bert_pkg;

  // x^7 + x^6 + 1
  localparam int PRBS_ORDER = 7;

  // Fixed lane seeds, upper 7 bits nonzero so the stream never locks up
  localparam aib_cfg_pkg::lane_t LANE_SEED [aib_cfg_pkg::NUM_LANES] =
    '{16'hACE1, 16'h5A3C, 16'hC0DE, 16'h1F2B};

  localparam int ERR_CNT_W = 16;           // Bit error counter width

  typedef logic [ERR_CNT_W-1:0] err_cnt_t;

  //------------------------------------------------------------------------
  // Parallel PRBS step
  //------------------------------------------------------------------------
  // Bit 0 of a word is the oldest bit on the serial stream. Every new bit
  // is the XOR of the bits PRBS_ORDER and PRBS_ORDER-1 places back, so the
  // upper bits of the new word depend on its own lower bits.
  function automatic aib_cfg_pkg::lane_t prbs_next(aib_cfg_pkg::lane_t prev);
    logic [2*aib_cfg_pkg::LANE_W-1:0] strm;  // Old word then new word
    strm = {{aib_cfg_pkg::LANE_W{1'b0}}, prev};
    for (int i = aib_cfg_pkg::LANE_W; i < 2 * aib_cfg_pkg::LANE_W; i++)
    begin
      strm[i] = strm[i-PRBS_ORDER] ^ strm[i-PRBS_ORDER+1]; // Taps 7 and 6
    end
    return strm[2*aib_cfg_pkg::LANE_W-1:aib_cfg_pkg::LANE_W];
  endfunction

endpackage

/* aib_bert_cfg_if.sv */
//--------------------------------------------------------------------------
// BERT and loopback control bundle
// Synchronized mode levels and BERT pulses from the control block
//--------------------------------------------------------------------------

`timescale 1ns/1ps

interface aib_bert_cfg_if;

  logic f_lpbk;                            // Far-side loopback active
  logic bert_en;                           // TX BERT replaces user data
  logic tx_start;                          // TX BERT start, one cycle
  logic tx_rst;                            // TX BERT reset, one cycle
  logic rx_start;                          // RX BERT start, one cycle
  logic rx_rst;                            // RX BERT reset, one cycle

  // Control block drives everything
  modport ctrl
  (
    output f_lpbk, bert_en, tx_start, tx_rst, rx_start, rx_rst
  );

  // Data path only needs the mode levels
  modport dpath (input f_lpbk, bert_en);

  // Generator control pulses
  modport gen (input tx_start, tx_rst);

  // Checker control pulses
  modport chk (input rx_start, rx_rst);

endinterface

/* aib_rd_ctrl.sv */
//--------------------------------------------------------------------------
// Read slice control
// Synchronizes the CSR levels into the read clock domain, decodes far-side
// loopback and turns BERT start and reset levels into single pulses
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module aib_rd_ctrl
(
  input  logic                    m_rd_clk_g,      // Read domain clock
  input  logic                    rxrd_fifo_rstn,  // Async reset, active low
  input  aib_cfg_pkg::lpbk_mode_t i_csr_lpbk_mode, // Loopback mode CSR
  input  logic                    i_tx_bert_en,    // TX BERT enable level
  input  logic                    i_tx_bert_start, // TX BERT start level
  input  logic                    i_tx_bert_rst,   // TX BERT reset level
  input  logic                    i_rxbert_start,  // RX BERT start level
  input  logic                    i_rxbert_rst,    // RX BERT reset level
  aib_bert_cfg_if.ctrl            cfg              // Mode bits and pulses
);

  localparam int LVL_W = 7;                // Mode field plus five bits

  logic [LVL_W-1:0]                        lvl_in;     // Raw CSR levels
  logic [aib_cfg_pkg::SYNC_STAGES-1:0][LVL_W-1:0] lvl_sync_q; // Sync chain
  logic [LVL_W-1:0]                        lvl_s;      // Synchronized levels
  logic [3:0]                              bert_d_q;   // Last BERT levels
  logic [3:0]                              bert_rise;  // Rising edges
  logic [3:0]                              pulse_q;    // Registered pulses

  // Bit order {mode[1:0], bert_en, tx_start, tx_rst, rx_start, rx_rst}
  assign lvl_in = {i_csr_lpbk_mode, i_tx_bert_en, i_tx_bert_start,
                   i_tx_bert_rst, i_rxbert_start, i_rxbert_rst};

  //------------------------------------------------------------------------
  // Level synchronizers
  //------------------------------------------------------------------------
  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
    begin
      lvl_sync_q <= '0;
    end
    else
    begin
      lvl_sync_q <= {lvl_sync_q[aib_cfg_pkg::SYNC_STAGES-2:0], lvl_in}; // Shift in
    end
  end

  assign lvl_s = lvl_sync_q[aib_cfg_pkg::SYNC_STAGES-1]; // Last stage

  // Mode levels straight from the synchronizer
  assign cfg.f_lpbk  = (lvl_s[6:5] == aib_cfg_pkg::LPBK_FARSIDE);
  assign cfg.bert_en = lvl_s[4];

  //------------------------------------------------------------------------
  // BERT edge detect
  //------------------------------------------------------------------------
  assign bert_rise = lvl_s[3:0] & ~bert_d_q;    // Low to high this cycle

  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
    begin
      bert_d_q <= '0;
      pulse_q  <= '0;
    end
    else
    begin
      bert_d_q   <= lvl_s[3:0];
      pulse_q[3] <= bert_rise[3] & ~bert_rise[2]; // TX start, reset wins
      pulse_q[2] <= bert_rise[2];                 // TX reset
      pulse_q[1] <= bert_rise[1] & ~bert_rise[0]; // RX start, reset wins
      pulse_q[0] <= bert_rise[0];                 // RX reset
    end
  end

  assign cfg.tx_start = pulse_q[3];
  assign cfg.tx_rst   = pulse_q[2];
  assign cfg.rx_start = pulse_q[1];
  assign cfg.rx_rst   = pulse_q[0];

endmodule

/* aib_rd_datapath.sv */
//--------------------------------------------------------------------------
// Read slice data path
// FIFO-mode data capture, output registers and transmit source select
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module aib_rd_datapath
(
  input  logic              m_rd_clk_g,     // Read domain clock
  input  logic              rxrd_fifo_rstn, // Async reset, active low
  input  aib_cfg_pkg::bus_t i_data_in_f,    // User write data from MAC
  input  aib_cfg_pkg::bus_t i_aibio_din,    // Received IO data
  input  aib_cfg_pkg::bus_t i_tx_pat,       // BERT pattern
  output aib_cfg_pkg::bus_t o_rx_word,      // Registered RX data
  output aib_cfg_pkg::bus_t o_aibio_dout,   // Transmit IO data
  aib_bert_cfg_if.dpath     cfg             // Loopback and BERT levels
);

  aib_cfg_pkg::bus_t din_f_q;               // User data input register
  aib_cfg_pkg::bus_t rx_q;                  // RX data output register
  aib_cfg_pkg::bus_t tx_src;                // Selected TX source
  aib_cfg_pkg::bus_t dout_q;                // TX IO output register

  // User data capture
  always_ff @(posedge m_rd_clk_g)
  begin
    din_f_q <= i_data_in_f;
  end

  //------------------------------------------------------------------------
  // Output registers
  //------------------------------------------------------------------------
  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
    begin
      rx_q   <= '0;
      dout_q <= '0;
    end
    else
    begin
      rx_q   <= i_aibio_din;              // FIFO read data to MAC
      dout_q <= tx_src;
    end
  end

  // Loopback beats BERT, BERT beats user data
  always_comb
  begin
    if (cfg.f_lpbk)
      tx_src = rx_q;                      // Turn RX data around
    else if (cfg.bert_en)
      tx_src = i_tx_pat;
    else
      tx_src = din_f_q;
  end

  assign o_rx_word    = rx_q;
  assign o_aibio_dout = dout_q;

endmodule

/* aib_bert_gen.sv */
//--------------------------------------------------------------------------
// TX BERT generator
// One PRBS7 word state per lane, seeded from the package, stepped every
// cycle while running
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module aib_bert_gen #(
  parameter int NUM_LANES = aib_cfg_pkg::NUM_LANES // Lanes to generate
)
(
  input  logic              m_rd_clk_g,     // Read domain clock
  input  logic              rxrd_fifo_rstn, // Async reset, active low
  aib_bert_cfg_if.gen       cfg,            // Start and reset pulses
  output aib_cfg_pkg::bus_t o_tx_pat,       // Pattern to the data path
  output logic              o_txbert_run    // Generator running
);

  aib_cfg_pkg::bus_t seed_w;                // Seed words per lane
  aib_cfg_pkg::bus_t next_w;                // Stepped lane words
  aib_cfg_pkg::bus_t lane_q;                // Current lane words
  logic              run_q;                 // Run flag

  //------------------------------------------------------------------------
  // Seed and next-word generation
  //------------------------------------------------------------------------
  always_comb
  begin
    seed_w = '0;
    next_w = '0;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      seed_w[l] = aib_bert_pkg::LANE_SEED[l];
      next_w[l] = aib_bert_pkg::prbs_next(lane_q[l]); // One word ahead
    end
  end

  //------------------------------------------------------------------------
  // Lane state and run flag
  //------------------------------------------------------------------------
  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
    begin
      run_q  <= 1'b0;
      lane_q <= seed_w;                   // Ready to start without tx_rst
    end
    else if (cfg.tx_rst)
    begin
      run_q  <= 1'b0;                     // Reset wins over start
      lane_q <= seed_w;
    end
    else
    begin
      if (cfg.tx_start)
        run_q <= 1'b1;
      if (run_q)
        lane_q <= next_w;                 // Advance all lanes
    end
  end

  assign o_tx_pat     = run_q ? lane_q : '0; // Quiet when idle
  assign o_txbert_run = run_q;

endmodule

/* aib_bert_chk.sv */
//--------------------------------------------------------------------------
// RX BERT checker
// Self-seeds from received data, predicts each next lane word and counts
// mismatching bits into a saturating counter with a sticky error flag
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module aib_bert_chk #(
  parameter int NUM_LANES = aib_cfg_pkg::NUM_LANES, // Lanes to check
  parameter bit ERR_SAT   = 1'b1                    // Hold count at all ones
)
(
  input  logic                   m_rd_clk_g,      // Read domain clock
  input  logic                   rxrd_fifo_rstn,  // Async reset, active low
  aib_bert_cfg_if.chk            cfg,             // Start and reset pulses
  input  aib_cfg_pkg::bus_t      i_rx_word,       // Registered RX data
  output logic                   o_rxbert_run,    // Checker running
  output logic                   o_rxbert_biterr, // Sticky bit error flag
  output aib_bert_pkg::err_cnt_t o_biterr_cnt     // Bit error count
);

  localparam int NERR_W = $clog2(NUM_LANES * aib_cfg_pkg::LANE_W + 1);
  localparam int SUM_W  = aib_bert_pkg::ERR_CNT_W + 1; // Count plus carry

  aib_cfg_pkg::bus_t      prev_q;           // Last received word
  aib_cfg_pkg::bus_t      diff;             // Mismatch bits per lane
  logic [NERR_W-1:0]      nerr;             // Mismatches this cycle
  logic [SUM_W-1:0]       cnt_sum;          // Count plus new errors
  aib_bert_pkg::err_cnt_t cnt_nxt;          // Saturated or wrapped count
  aib_bert_pkg::err_cnt_t cnt_q;            // Error count
  logic                   run_q;            // Run flag
  logic                   err_q;            // Sticky error flag

  //------------------------------------------------------------------------
  // Prediction and mismatch count
  //------------------------------------------------------------------------
  always_comb
  begin
    diff = '0;
    nerr = '0;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      diff[l] = i_rx_word[l] ^ aib_bert_pkg::prbs_next(prev_q[l]);
      for (int b = 0; b < aib_cfg_pkg::LANE_W; b++)
        nerr = nerr + NERR_W'(diff[l][b]); // Popcount
    end
  end

  assign cnt_sum = {1'b0, cnt_q} + SUM_W'(nerr);
  assign cnt_nxt = (ERR_SAT && cnt_sum[SUM_W-1]) ? '1 :
                   cnt_sum[aib_bert_pkg::ERR_CNT_W-1:0];

  // Seed register, loaded on start and on every running cycle
  always_ff @(posedge m_rd_clk_g)
  begin
    if (cfg.rx_start || run_q)
      prev_q <= i_rx_word;
  end

  //------------------------------------------------------------------------
  // Status registers
  //------------------------------------------------------------------------
  always_ff @(posedge m_rd_clk_g or negedge rxrd_fifo_rstn)
  begin
    if (!rxrd_fifo_rstn)
    begin
      run_q <= 1'b0;
      err_q <= 1'b0;
      cnt_q <= '0;
    end
    else if (cfg.rx_rst)
    begin
      run_q <= 1'b0;                      // Reset wins over start
      err_q <= 1'b0;
      cnt_q <= '0;
    end
    else if (cfg.rx_start)
    begin
      run_q <= 1'b1;                      // First word is only the seed
    end
    else if (run_q)
    begin
      cnt_q <= cnt_nxt;
      if (nerr != '0)
        err_q <= 1'b1;                    // Sticky until rx_rst
    end
  end

  assign o_rxbert_run    = run_q;
  assign o_rxbert_biterr = err_q;
  assign o_biterr_cnt    = cnt_q;

endmodule

/* aib_rd_top.sv */
//--------------------------------------------------------------------------
// AIB adapter far-side read slice
// Control, data path, BERT generator and BERT checker on the read clock
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module aib_rd_top #(
  parameter int NUM_LANES = aib_cfg_pkg::NUM_LANES, // Lanes per bus
  parameter bit ERR_SAT   = 1'b1                    // Saturating error count
)
(
  input  logic                    m_rd_clk_g,      // Read domain clock
  input  logic                    rxrd_fifo_rstn,  // Async reset, active low
  input  aib_cfg_pkg::lpbk_mode_t i_csr_lpbk_mode, // Loopback mode CSR
  input  logic                    i_tx_bert_en,    // TX BERT enable
  input  logic                    i_tx_bert_start, // TX BERT start level
  input  logic                    i_tx_bert_rst,   // TX BERT reset level
  input  logic                    i_rxbert_start,  // RX BERT start level
  input  logic                    i_rxbert_rst,    // RX BERT reset level
  input  aib_cfg_pkg::bus_t       i_data_in_f,     // User data from MAC
  input  aib_cfg_pkg::bus_t       i_aibio_din,     // From IO buffer
  output aib_cfg_pkg::bus_t       o_data_out_f,    // FIFO read data to MAC
  output aib_cfg_pkg::bus_t       o_aibio_dout,    // To IO buffer
  output logic                    o_txbert_run,    // TX BERT running
  output logic                    o_rxbert_run,    // RX BERT running
  output logic                    o_rxbert_biterr, // RX BERT error seen
  output aib_bert_pkg::err_cnt_t  o_biterr_cnt     // RX BERT error count
);

  aib_cfg_pkg::bus_t tx_pat;                // Generator to data path
  aib_cfg_pkg::bus_t rx_word;               // Data path to checker

  aib_bert_cfg_if cfg_if ();

  aib_rd_ctrl u_ctrl (
    .m_rd_clk_g      (m_rd_clk_g),
    .rxrd_fifo_rstn  (rxrd_fifo_rstn),
    .i_csr_lpbk_mode (i_csr_lpbk_mode),
    .i_tx_bert_en    (i_tx_bert_en),
    .i_tx_bert_start (i_tx_bert_start),
    .i_tx_bert_rst   (i_tx_bert_rst),
    .i_rxbert_start  (i_rxbert_start),
    .i_rxbert_rst    (i_rxbert_rst),
    .cfg             (cfg_if.ctrl)
  );

  aib_rd_datapath u_dpath (
    .m_rd_clk_g     (m_rd_clk_g),
    .rxrd_fifo_rstn (rxrd_fifo_rstn),
    .i_data_in_f    (i_data_in_f),
    .i_aibio_din    (i_aibio_din),
    .i_tx_pat       (tx_pat),
    .o_rx_word      (rx_word),
    .o_aibio_dout   (o_aibio_dout),
    .cfg            (cfg_if.dpath)
  );

  aib_bert_gen #(.NUM_LANES (NUM_LANES)) u_gen (
    .m_rd_clk_g     (m_rd_clk_g),
    .rxrd_fifo_rstn (rxrd_fifo_rstn),
    .cfg            (cfg_if.gen),
    .o_tx_pat       (tx_pat),
    .o_txbert_run   (o_txbert_run)
  );

  aib_bert_chk #(.NUM_LANES (NUM_LANES), .ERR_SAT (ERR_SAT)) u_chk (
    .m_rd_clk_g      (m_rd_clk_g),
    .rxrd_fifo_rstn  (rxrd_fifo_rstn),
    .cfg             (cfg_if.chk),
    .i_rx_word       (rx_word),
    .o_rxbert_run    (o_rxbert_run),
    .o_rxbert_biterr (o_rxbert_biterr),
    .o_biterr_cnt    (o_biterr_cnt)
  );

  assign o_data_out_f = rx_word;            // Same register feeds the MAC

endmodule

/* aib_rd_assertions.sv */
//--------------------------------------------------------------------------
// BERT status assertions
// Bound into the generator and the checker
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module aib_rd_assertions
(
  input logic                   m_rd_clk_g,     // Read domain clock
  input logic                   rxrd_fifo_rstn, // Async reset, active low
  input logic                   i_run,          // Run flag
  input logic                   i_err,          // Sticky error flag
  input aib_bert_pkg::err_cnt_t i_cnt,          // Error count
  input logic                   i_clr           // BERT reset pulse
);

  // Run flag held low in reset
  run_low_in_reset: assert property (@(posedge m_rd_clk_g) !rxrd_fifo_rstn |-> !i_run)
    else $error("run flag high while in reset");

  // Error flag only clears through the BERT reset pulse
  err_sticky: assert property (@(posedge m_rd_clk_g) disable iff (!rxrd_fifo_rstn)
    $fell(i_err) |-> $past(i_clr))
    else $error("error flag cleared without a BERT reset");

  // Count only grows while running
  cnt_no_decrease: assert property (@(posedge m_rd_clk_g) disable iff (!rxrd_fifo_rstn)
    (i_run && $past(i_run)) |-> (i_cnt >= $past(i_cnt)))
    else $error("error count decreased while running");

endmodule

/* tb_aib_rd_top.sv */
//--------------------------------------------------------------------------
// Testbench for the AIB far-side read slice
// Random stimulus, cycle model of data path and BERT, watchdog
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_aib_rd_top;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYC    = 10;
  localparam int SEED       = 37;
  localparam int BUS_W      = aib_cfg_pkg::NUM_LANES * aib_cfg_pkg::LANE_W;
  localparam int CNT_MAX    = (1 << aib_bert_pkg::ERR_CNT_W) - 1;
  localparam int PH_DATA    = 200;         // Cycles per data phase
  localparam int PH_SAT     = 2600;        // Enough random words to saturate
  localparam int REQ_CYC    = 9;           // Cycles per BERT request
  localparam int TOTAL_CYC  = RST_CYC + 6 * PH_DATA + PH_SAT + 6 * REQ_CYC + 20;
  localparam int WDOG_NS    = (TOTAL_CYC + 200) * CLK_PERIOD;

  logic                    m_rd_clk_g;
  logic                    rxrd_fifo_rstn;
  aib_cfg_pkg::lpbk_mode_t i_csr_lpbk_mode;
  logic                    i_tx_bert_en, i_tx_bert_start, i_tx_bert_rst;
  logic                    i_rxbert_start, i_rxbert_rst;
  aib_cfg_pkg::bus_t       i_data_in_f, i_aibio_din;
  aib_cfg_pkg::bus_t       o_data_out_f, o_aibio_dout;
  logic                    o_txbert_run, o_rxbert_run, o_rxbert_biterr;
  aib_bert_pkg::err_cnt_t  o_biterr_cnt;

  // Model state
  aib_cfg_pkg::bus_t din_d1, din_d2;       // IO input history
  aib_cfg_pkg::bus_t dinf_d1, dinf_d2;     // User input history
  aib_cfg_pkg::bus_t gen_word;             // Next expected pattern word
  aib_cfg_pkg::bus_t chk_prev;             // Checker's previous word
  bit                gen_act, chk_act, err_m;
  bit                tx_is_rst, rx_is_rst;
  bit                fb, flip_en;          // Loop dout back and inject flips
  int                cnt_m, tx_cd, rx_cd, settle;

  aib_rd_top u_dut (.*);

  bind aib_bert_chk aib_rd_assertions u_chk_sva (
    .m_rd_clk_g (m_rd_clk_g), .rxrd_fifo_rstn (rxrd_fifo_rstn),
    .i_run (run_q), .i_err (err_q), .i_cnt (cnt_q), .i_clr (cfg.rx_rst)
  );
  bind aib_bert_gen aib_rd_assertions u_gen_sva (
    .m_rd_clk_g (m_rd_clk_g), .rxrd_fifo_rstn (rxrd_fifo_rstn),
    .i_run (run_q), .i_err (1'b0), .i_cnt ('0), .i_clr (cfg.tx_rst)
  );

  always #(CLK_PERIOD / 2) m_rd_clk_g = ~m_rd_clk_g;

  //------------------------------------------------------------------------
  // Helpers and compare tasks
  //------------------------------------------------------------------------
  task automatic report_fail(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_bus(input aib_cfg_pkg::bus_t got, input aib_cfg_pkg::bus_t exp,
                           input string name);
    if (got !== exp)
      report_fail($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_cnt(input aib_bert_pkg::err_cnt_t got,
                           input aib_bert_pkg::err_cnt_t exp, input string name);
    if (got !== exp)
      report_fail($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp)
      report_fail($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic aib_cfg_pkg::bus_t rand_bus();
    aib_cfg_pkg::bus_t b;
    for (int l = 0; l < aib_cfg_pkg::NUM_LANES; l++)
      b[l] = aib_cfg_pkg::lane_t'($urandom());
    return b;
  endfunction

  function automatic aib_cfg_pkg::bus_t seed_bus();
    aib_cfg_pkg::bus_t b;
    for (int l = 0; l < aib_cfg_pkg::NUM_LANES; l++)
      b[l] = aib_bert_pkg::LANE_SEED[l];
    return b;
  endfunction

  //------------------------------------------------------------------------
  // One falling edge per cycle to model, compare and drive
  //------------------------------------------------------------------------
  task automatic tick(input int n);
    aib_cfg_pkg::bus_t exp_pat;
    aib_cfg_pkg::bus_t exp_dout;
    aib_cfg_pkg::bus_t nxt_din;
    logic [BUS_W-1:0]  flip_v;
    int                nbit;
    repeat (n)
    begin
      @(negedge m_rd_clk_g);
      exp_pat = '0;                        // Idle generator sends zeros
      if (gen_act)
      begin
        exp_pat = gen_word;
        for (int l = 0; l < aib_cfg_pkg::NUM_LANES; l++)
          gen_word[l] = aib_bert_pkg::prbs_next(gen_word[l]);
      end
      if (i_csr_lpbk_mode == aib_cfg_pkg::LPBK_FARSIDE)
        exp_dout = din_d2;                 // RX data turned around
      else if (i_tx_bert_en)
        exp_dout = exp_pat;
      else
        exp_dout = dinf_d2;
      if (tx_cd > 0)
      begin
        tx_cd--;
        if (tx_cd == 0)
        begin
          gen_act  = !tx_is_rst;           // Pulse reaches the generator
          gen_word = seed_bus();
        end
      end
      if (chk_act)
      begin
        nbit = 0;
        for (int l = 0; l < aib_cfg_pkg::NUM_LANES; l++)
          nbit += $countones(din_d2[l] ^ aib_bert_pkg::prbs_next(chk_prev[l]));
        cnt_m    = (cnt_m + nbit > CNT_MAX) ? CNT_MAX : cnt_m + nbit;
        err_m    = err_m | (nbit != 0);
        chk_prev = din_d2;
      end
      if (rx_cd > 0)
      begin
        rx_cd--;
        if (rx_cd == 0)
        begin
          chk_act  = !rx_is_rst;
          chk_prev = din_d2;               // Self-seed word
          if (rx_is_rst)
          begin
            cnt_m = 0;
            err_m = 1'b0;
          end
        end
      end
      check_bus(o_data_out_f, din_d1, "o_data_out_f");
      if (settle == 0)
        check_bus(o_aibio_dout, exp_dout, "o_aibio_dout");
      else
        settle--;
      check_flag(o_txbert_run, gen_act, "o_txbert_run");
      check_flag(o_rxbert_run, chk_act, "o_rxbert_run");
      check_flag(o_rxbert_biterr, err_m, "o_rxbert_biterr");
      check_cnt(o_biterr_cnt, aib_bert_pkg::err_cnt_t'(cnt_m), "o_biterr_cnt");
      flip_v = '0;
      if (flip_en && ($urandom() % 8 == 0))
        flip_v = 64'd1 << ($urandom() % BUS_W); // Single-bit error
      nxt_din     = fb ? (o_aibio_dout ^ flip_v) : rand_bus();
      i_data_in_f = rand_bus();
      i_aibio_din = nxt_din;
      dinf_d2     = dinf_d1;
      dinf_d1     = i_data_in_f;
      din_d2      = din_d1;
      din_d1      = nxt_din;
    end
  endtask

  // Raise one BERT level, hold it, then drop all of them
  task automatic request_bert(input bit rx, input bit rst);
    if (rx)
    begin
      rx_is_rst = rst;
      rx_cd     = 4;                       // 3 sync cycles plus the flag flop
      if (rst)
        i_rxbert_rst = 1'b1;
      else
        i_rxbert_start = 1'b1;
    end
    else
    begin
      tx_is_rst = rst;
      tx_cd     = 4;
      if (rst)
        i_tx_bert_rst = 1'b1;
      else
        i_tx_bert_start = 1'b1;
    end
    tick(6);
    {i_tx_bert_start, i_tx_bert_rst, i_rxbert_start, i_rxbert_rst} = '0;
    tick(REQ_CYC - 6);
  endtask

  task automatic set_mode(input aib_cfg_pkg::lpbk_mode_t mode, input logic bert);
    i_csr_lpbk_mode = mode;
    i_tx_bert_en    = bert;
    settle          = 4;                   // Mode passes the synchronizer
  endtask

  initial
  begin
    #(WDOG_NS);
    report_fail("Watchdog timeout, the test did not reach its end");
  end

  initial
  begin
    void'($urandom(SEED));
    m_rd_clk_g     = 1'b0;
    rxrd_fifo_rstn = 1'b0;
    i_csr_lpbk_mode = aib_cfg_pkg::LPBK_NONE;
    {i_tx_bert_en, i_tx_bert_start, i_tx_bert_rst} = '0;
    {i_rxbert_start, i_rxbert_rst} = '0;
    i_data_in_f = '0;
    i_aibio_din = '0;
    {din_d1, din_d2, dinf_d1, dinf_d2, gen_word, chk_prev} = '0;
    {gen_act, chk_act, err_m, tx_is_rst, rx_is_rst, fb, flip_en} = '0;
    {cnt_m, tx_cd, rx_cd} = '0;
    settle = 4;
    repeat (RST_CYC) @(negedge m_rd_clk_g);
    rxrd_fifo_rstn = 1'b1;

    tick(PH_DATA);                         // Pass-through
    set_mode(aib_cfg_pkg::LPBK_NEARSIDE, 1'b0);
    tick(PH_DATA / 2);
    set_mode(aib_cfg_pkg::LPBK_FARSIDE, 1'b0);
    tick(PH_DATA);
    set_mode(aib_cfg_pkg::LPBK_NONE, 1'b1); // Generator onto the IO bus
    fb = 1'b1;
    request_bert(1'b0, 1'b0);
    tick(PH_DATA);
    request_bert(1'b1, 1'b0);              // Clean check on looped data
    tick(PH_DATA);
    flip_en = 1'b1;
    tick(PH_DATA);
    check_flag(o_rxbert_biterr, 1'b1, "o_rxbert_biterr");
    flip_en = 1'b0;
    request_bert(1'b1, 1'b1);
    check_cnt(o_biterr_cnt, '0, "o_biterr_cnt");
    check_flag(o_rxbert_biterr, 1'b0, "o_rxbert_biterr");
    fb = 1'b0;                             // Random words until saturation
    request_bert(1'b1, 1'b0);
    tick(PH_SAT);
    check_cnt(o_biterr_cnt, '1, "o_biterr_cnt");
    request_bert(1'b0, 1'b1);
    set_mode(aib_cfg_pkg::LPBK_NONE, 1'b0);
    tick(20);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* filelist.f */
aib_cfg_pkg.sv
aib_bert_pkg.sv
aib_bert_cfg_if.sv
aib_rd_ctrl.sv
aib_rd_datapath.sv
aib_bert_gen.sv
aib_bert_chk.sv
aib_rd_top.sv
aib_rd_assertions.sv
tb_aib_rd_top.sv

/* Makefile */
# Verilator build and run for the AIB read slice testbench

VERILATOR ?= verilator
TOP       ?= tb_aib_rd_top
FLIST     ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
